/* hw/port_stats_pkg.sv */
`default_nettype none

package port_stats_pkg;

  // Byte lanes per monitored beat.
  localparam int keep_width = 8;

  // Counters are one word each and wrap on overflow.
  localparam int byte_count_width = 32;
  localparam int frame_count_width = 32;

  // One port's monitor tap as seen on the switch side.
  typedef struct packed {
    logic [keep_width-1:0] tkeep;
    logic                  tvalid;
    logic                  tready;
    logic                  tlast;
    logic                  drop_pulse; // Frame discarded by the switch.
  } monitor_tap_t;

  // Readout of one port, three words.
  typedef struct packed {
    logic [byte_count_width-1:0]  byte_count;
    logic [frame_count_width-1:0] frame_count;
    logic [frame_count_width-1:0] drop_count;
  } port_counts_t;

endpackage

`default_nettype wire

/* hw/axis_stat.sv */
`timescale 1ns/1ns
`default_nettype none

module axis_stat (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        port_rst,
  input  logic                        clear,
  input  port_stats_pkg::monitor_tap_t tap,
  output port_stats_pkg::port_counts_t counts
);

  localparam int kw = port_stats_pkg::keep_width;
  localparam int bw = port_stats_pkg::byte_count_width;
  localparam int fw = port_stats_pkg::frame_count_width;

  // Enough bits to hold a full beat's lane count.
  localparam int lane_bits = $clog2(kw + 1);

  logic                 accepted;
  logic                 zero_counts;
  logic [lane_bits-1:0] beat_bytes;
  logic [bw-1:0]        byte_count_q;
  logic [fw-1:0]        frame_count_q;
  logic [fw-1:0]        drop_count_q;

  function automatic logic [lane_bits-1:0] lane_count(input logic [kw-1:0] keep);
    logic [lane_bits-1:0] sum;
    sum = '0;
    for (int k = 0; k < kw; k++) begin
      sum = sum + {{(lane_bits-1){1'b0}}, keep[k]};
    end
    return sum;
  endfunction

  assign accepted    = tap.tvalid & tap.tready; // Handshake completes this cycle.
  assign zero_counts = clear | port_rst;
  assign beat_bytes  = lane_count(tap.tkeep);

  // Byte counter.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_count_q <= '0;
    end else if (zero_counts) begin
      byte_count_q <= '0; // The beat in this cycle is lost.
    end else if (accepted) begin
      byte_count_q <= byte_count_q + {{(bw-lane_bits){1'b0}}, beat_bytes};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_count_q <= '0;
    end else if (zero_counts) begin
      frame_count_q <= '0;
    end else if (accepted && tap.tlast) begin
      frame_count_q <= frame_count_q + 1'b1; // Last beat closes a frame.
    end
  end

  // Drops are counted apart from any beat activity.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_count_q <= '0;
    end else if (zero_counts) begin
      drop_count_q <= '0;
    end else if (tap.drop_pulse) begin
      drop_count_q <= drop_count_q + 1'b1;
    end
  end

  assign counts.byte_count  = byte_count_q;
  assign counts.frame_count = frame_count_q;
  assign counts.drop_count  = drop_count_q;

endmodule

`default_nettype wire

/* hw/stat_reader.sv */
`timescale 1ns/1ns
`default_nettype none

module stat_reader #(
  parameter int PORT_COUNT    = 4,
  parameter int PORT_CLUSTERS = 2
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [PORT_COUNT-1:0]        port_rst,
  input  logic [PORT_COUNT-1:0]        port_clear,
  input  port_stats_pkg::monitor_tap_t monitor [PORT_COUNT],
  input  logic [$clog2(PORT_COUNT)-1:0] port_select,
  output port_stats_pkg::port_counts_t counts
);

  localparam int port_width        = $clog2(PORT_COUNT);
  localparam int ceil_port_count   = 2 ** port_width;
  localparam int ports_per_cluster = ceil_port_count / PORT_CLUSTERS;
  localparam int low_sel_bits      = $clog2(ports_per_cluster);

  port_stats_pkg::monitor_tap_t tap_r [PORT_COUNT];

  logic [port_width-1:0]   port_select_r;
  logic [low_sel_bits-1:0] low_select_rr [PORT_CLUSTERS];

  port_stats_pkg::port_counts_t counts_all   [ceil_port_count];
  port_stats_pkg::port_counts_t counts_all_r [ceil_port_count];
  port_stats_pkg::port_counts_t cluster_r    [PORT_CLUSTERS];

  // Taps are registered once before counting.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PORT_COUNT; i++) begin
        tap_r[i] <= '0;
      end
    end else begin
      for (int i = 0; i < PORT_COUNT; i++) begin
        tap_r[i]        <= monitor[i];
        tap_r[i].tvalid <= monitor[i].tvalid & ~port_rst[i]; // No beats during port reset.
      end
    end
  end

  // Low select bits are copied per cluster to ease fanout.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      port_select_r <= '0;
      for (int c = 0; c < PORT_CLUSTERS; c++) begin
        low_select_rr[c] <= '0;
      end
    end else begin
      port_select_r <= port_select;
      for (int c = 0; c < PORT_CLUSTERS; c++) begin
        low_select_rr[c] <= port_select_r[low_sel_bits-1:0];
      end
    end
  end

  genvar g;

  for (g = 0; g < PORT_COUNT; g++) begin : g_port
    axis_stat u_axis_stat (
      .clk      (clk),
      .rst_n    (rst_n),
      .port_rst (port_rst[g]),
      .clear    (port_clear[g]),
      .tap      (tap_r[g]),
      .counts   (counts_all[g])
    );
  end

  // Unused port numbers up to the power of two read zero.
  for (g = PORT_COUNT; g < ceil_port_count; g++) begin : g_pad
    assign counts_all[g] = '0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ceil_port_count; i++) begin
        counts_all_r[i] <= '0;
      end
    end else begin
      for (int i = 0; i < ceil_port_count; i++) begin
        counts_all_r[i] <= counts_all[i];
      end
    end
  end

  // First level picks one port inside each cluster.
  for (g = 0; g < PORT_CLUSTERS; g++) begin : g_cluster
    logic [port_width-1:0] cluster_index;

    assign cluster_index = port_width'(g * ports_per_cluster) + port_width'(low_select_rr[g]);

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cluster_r[g] <= '0;
      end else begin
        cluster_r[g] <= counts_all_r[cluster_index];
      end
    end
  end

  // Second level picks the cluster.
  if (PORT_CLUSTERS == 1) begin : g_single
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        counts <= '0;
      end else begin
        counts <= cluster_r[0]; // Only a register stage here.
      end
    end
  end else begin : g_multi
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        counts <= '0;
      end else begin
        counts <= cluster_r[port_select_r[port_width-1:low_sel_bits]];
      end
    end
  end

endmodule

`default_nettype wire

/* hw/port_stats_top.sv */
`timescale 1ns/1ns
`default_nettype none

module port_stats_top #(
  parameter int PORT_COUNT    = 6,
  parameter int PORT_CLUSTERS = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [PORT_COUNT-1:0]         port_rst,
  input  logic [PORT_COUNT-1:0]         port_clear,
  input  port_stats_pkg::monitor_tap_t  monitor [PORT_COUNT],
  input  logic [$clog2(PORT_COUNT)-1:0] port_select,
  output port_stats_pkg::port_counts_t  counts
);

  // Six ports in two clusters of four, so ports 6 and 7 are padding.
  stat_reader #(
    .PORT_COUNT    (PORT_COUNT),
    .PORT_CLUSTERS (PORT_CLUSTERS)
  ) u_stat_reader (
    .clk         (clk),
    .rst_n       (rst_n),
    .port_rst    (port_rst),
    .port_clear  (port_clear),
    .monitor     (monitor),
    .port_select (port_select),
    .counts      (counts)
  );

endmodule

`default_nettype wire

/* dv/tb_port_stats_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_port_stats_top;

  localparam int  port_count = 6;
  localparam int  sel_width  = $clog2(port_count);
  localparam time clk_period = 40;
  localparam time run_limit  = 200_000;

  logic                         clk;
  logic                         rst_n;
  logic [port_count-1:0]        port_rst;
  logic [port_count-1:0]        port_clear;
  port_stats_pkg::monitor_tap_t monitor [port_count];
  logic [sel_width-1:0]         port_select;
  port_stats_pkg::port_counts_t counts;

  int test_errors;
  int tests_passed;
  int tests_failed;

  port_stats_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .port_rst    (port_rst),
    .port_clear  (port_clear),
    .monitor     (monitor),
    .port_select (port_select),
    .counts      (counts)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  initial begin
    #(run_limit);
    $display("Timeout: the run hung and did not reach the end of the case file.");
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic wait_edges(input int n);
    int  waited;
    time limit;
    waited = 0;
    limit  = $time + (n + 1) * clk_period;
    while (waited < n && $time <= limit) begin
      @(posedge clk);
      waited++;
    end
    if (waited < n) begin
      $display("Timeout: %0d clock edges did not arrive in time.", n);
      test_errors++;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
      test_errors++;
    end
  endtask

  // One tap value for a single cycle, then a short random gap.
  task automatic drive_tap(input int port, input port_stats_pkg::monitor_tap_t tap);
    wait_edges(1);
    monitor[port] <= tap;
    wait_edges(1);
    monitor[port] <= '0;
    wait_edges(int'($urandom % 4));
  endtask

  task automatic pulse_clear(input int port);
    wait_edges(1);
    port_clear[port] <= 1'b1;
    wait_edges(1);
    port_clear[port] <= 1'b0;
  endtask

  task automatic set_port_reset(input int port, input logic level);
    wait_edges(1);
    port_rst[port] <= level;
  endtask

  task automatic apply_reset(input int cycles);
    wait_edges(1);
    rst_n <= 1'b0;
    wait_edges(cycles);
    rst_n <= 1'b1;
  endtask

  task automatic check_port(input int port, input int bytes, input int frames, input int drops);
    wait_edges(1);
    port_select <= sel_width'(port);
    wait_edges(8); // Covers the counter and the readout pipeline.
    check_value($sformatf("port%0d byte_count", port), bytes, counts.byte_count);
    check_value($sformatf("port%0d frame_count", port), frames, counts.frame_count);
    check_value($sformatf("port%0d drop_count", port), drops, counts.drop_count);
  endtask

  task automatic close_test(input string name);
    if (test_errors == 0) begin
      $display("Test %s: passed", name);
      tests_passed++;
    end else begin
      $display("Test %s: failed with %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial begin
    int                                    fd;
    int                                    fields;
    int                                    a;
    int                                    b;
    int                                    c;
    int                                    d;
    logic [port_stats_pkg::keep_width-1:0] keep;
    string                                 line;
    string                                 kind;
    string                                 name;
    port_stats_pkg::monitor_tap_t          tap;

    void'($urandom(32'h1d31bd16));
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    port_rst     = '0;
    port_clear   = '0;
    port_select  = '0;
    for (int i = 0; i < port_count; i++) begin
      monitor[i] = '0;
    end
    wait_edges(4);
    rst_n <= 1'b1;

    fd = $fopen("dv/port_stats_cases.txt", "r");
    if (fd == 0) begin
      $display("The case file dv/port_stats_cases.txt could not be opened.");
      test_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        kind = "";
        void'($fgets(line, fd));
        fields = $sscanf(line, "%s", kind);
        if (fields < 1 || kind.substr(0, 0) == "#") begin
          // Blank and comment lines carry no stimulus.
        end else if (kind == "beat") begin
          void'($sscanf(line, "%s %d %h %d %d %d", kind, a, keep, b, c, d));
          tap        = '0;
          tap.tkeep  = keep;
          tap.tvalid = b[0];
          tap.tready = c[0];
          tap.tlast  = d[0];
          drive_tap(a, tap);
        end else if (kind == "drop") begin
          void'($sscanf(line, "%s %d", kind, a));
          tap            = '0;
          tap.drop_pulse = 1'b1;
          drive_tap(a, tap);
        end else if (kind == "clear") begin
          void'($sscanf(line, "%s %d", kind, a));
          pulse_clear(a);
        end else if (kind == "prst") begin
          void'($sscanf(line, "%s %d %d", kind, a, b));
          set_port_reset(a, b[0]);
        end else if (kind == "idle") begin
          void'($sscanf(line, "%s %d", kind, a));
          wait_edges(a);
        end else if (kind == "reset") begin
          void'($sscanf(line, "%s %d", kind, a));
          apply_reset(a);
        end else if (kind == "check") begin
          void'($sscanf(line, "%s %d %d %d %d", kind, a, b, c, d));
          check_port(a, b, c, d);
        end else if (kind == "end") begin
          void'($sscanf(line, "%s %s", kind, name));
          close_test(name);
        end else begin
          $display("The case file holds an unknown line kind: %s", kind);
          test_errors++;
        end
      end
      $fclose(fd);
    end

    if (test_errors != 0) begin
      $display("Checks outside any named test failed with %0d errors", test_errors);
      tests_failed++;
    end
    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && tests_passed > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* port_stats_top.f */
hw/port_stats_pkg.sv
hw/axis_stat.sv
hw/stat_reader.sv
hw/port_stats_top.sv
dv/tb_port_stats_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_port_stats_top
FILELIST  := port_stats_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/port_stats_cases.txt */
# beat port keep(hex) valid ready last | drop port | clear port | prst port level
# idle cycles | reset cycles | check port bytes frames drops | end test_name
beat 0 ff 1 1 0
beat 0 0f 1 1 0
beat 0 ff 0 1 0
beat 0 ff 1 0 0
beat 0 81 1 1 1
beat 0 3c 1 1 0
check 0 18 1 0
end byte_count
beat 2 ff 1 1 0
beat 2 07 1 1 1
beat 2 01 1 0 1
drop 2
beat 2 f0 1 1 1
drop 2
drop 2
check 2 15 2 3
end frame_drop
beat 1 ff 1 1 1
beat 4 0f 1 1 1
drop 1
beat 4 ff 1 1 0
drop 4
check 1 8 1 1
check 4 12 1 1
clear 1
check 1 0 0 0
check 4 12 1 1
end isolation_clear
beat 3 ff 1 1 1
drop 3
check 3 8 1 1
prst 3 1
beat 3 ff 1 1 1
idle 2
prst 3 0
check 3 0 0 0
beat 3 0f 1 1 1
check 3 4 1 0
end port_reset
beat 5 ff 1 1 1
drop 5
beat 1 03 1 1 0
check 0 18 1 0
check 1 2 0 0
check 2 15 2 3
check 3 4 1 0
check 4 12 1 1
check 5 8 1 1
check 6 0 0 0
check 7 0 0 0
end cluster_select
idle 3
reset 4
check 0 0 0 0
check 2 0 0 0
check 4 0 0 0
check 5 0 0 0
end global_reset
